//--- verilog.f
+incdir+rtl
rtl/mems_hub_pkg.sv
rtl/mems_spi_master.sv
rtl/poll_sequencer.sv
rtl/sample_collector.sv
rtl/mems_sensor_hub.sv
sim/spi_sensor_model.sv
sim/tb_mems_sensor_hub.sv

//--- Makefile
TOP = tb_mems_sensor_hub

RTL = rtl/mems_hub_pkg.sv rtl/mems_spi_master.sv rtl/poll_sequencer.sv \
      rtl/sample_collector.sv rtl/mems_sensor_hub.sv

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

lint:
	verilator --lint-only +incdir+rtl $(RTL) --top-module mems_sensor_hub

clean:
	rm -rf obj_dir

//--- sim/tb_mems_sensor_hub.sv
`timescale 1ns/100ps
`default_nettype none

`include "mems_hub_macros.svh"

module tb_mems_sensor_hub;

  localparam int WAIT_LIMIT = 400; // cycles, well above one frame
  localparam logic [`MEMS_NUM_CH-1:0] ALL_CH = '1;
  localparam logic [`MEMS_NUM_CH-1:0] NO_CH  = '0;

  logic                                     clk;
  logic                                     rst;
  logic                                     cmd_valid;
  mems_hub_pkg::hub_cmd_t                   cmd;
  wire  [`MEMS_NUM_CH-1:0]                  miso;
  logic [`MEMS_NUM_CH-1:0]                  mosi;
  logic [`MEMS_NUM_CH-1:0]                  sck;
  logic [`MEMS_NUM_CH-1:0]                  cs_n;
  logic                                     busy;
  logic                                     result_valid;
  mems_hub_pkg::hub_result_t                result;
  logic [6:0]                               peek_addr;
  wire  [`MEMS_NUM_CH-1:0][`MEMS_DATA_W-1:0] peek_data;

  logic [`MEMS_DATA_W-1:0]   shadow [`MEMS_NUM_CH][128]; // expected sensor registers
  mems_hub_pkg::hub_result_t expect_q [$];
  integer                    seed;
  int                        result_errors;
  int                        check_errors;
  int                        timeout_errors;

  mems_sensor_hub u_mems_sensor_hub (
    .clk          (clk),
    .rst          (rst),
    .cmd_valid    (cmd_valid),
    .cmd          (cmd),
    .miso         (miso),
    .mosi         (mosi),
    .sck          (sck),
    .cs_n         (cs_n),
    .busy         (busy),
    .result_valid (result_valid),
    .result       (result)
  );

  for (genvar ch = 0; ch < `MEMS_NUM_CH; ch++) begin : g_model
    spi_sensor_model u_spi_sensor_model (
      .cs_n      (cs_n[ch]),
      .sck       (sck[ch]),
      .mosi      (mosi[ch]),
      .miso      (miso[ch]),
      .peek_addr (peek_addr),
      .peek_data (peek_data[ch])
    );
  end

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // reads return the shadow on masked channels, writes update it
  function automatic mems_hub_pkg::hub_result_t predict_result(
    input mems_hub_pkg::hub_cmd_t c
  );
    mems_hub_pkg::hub_result_t r;
    r.op    = c.op;
    r.mask  = c.mask;
    r.rdata = '0;
    for (int ch = 0; ch < `MEMS_NUM_CH; ch++) begin
      if (c.mask[ch]) begin
        if (c.op == mems_hub_pkg::op_read) begin
          r.rdata[ch] = shadow[ch][c.addr];
        end else begin
          shadow[ch][c.addr] = c.wdata;
        end
      end
    end
    return r;
  endfunction

  function automatic mems_hub_pkg::hub_cmd_t make_cmd(
    input mems_hub_pkg::hub_op_e       op,
    input logic [6:0]              addr,
    input logic [`MEMS_DATA_W-1:0] wdata,
    input logic [`MEMS_NUM_CH-1:0] mask
  );
    mems_hub_pkg::hub_cmd_t c;
    c.op    = op;
    c.addr  = addr;
    c.wdata = wdata;
    c.mask  = mask;
    return c;
  endfunction

  task automatic check_result(
    input mems_hub_pkg::hub_result_t got,
    input mems_hub_pkg::hub_result_t exp
  );
    if (got !== exp) begin
      result_errors++;
      $display("Fail %0t: result got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_reg(
    input logic [`MEMS_DATA_W-1:0] got,
    input logic [`MEMS_DATA_W-1:0] exp,
    input string                   what
  );
    if (got !== exp) begin
      check_errors++;
      $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      check_errors++;
      $display("Fail %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // compare process, one expected entry per result_valid
  always @(negedge clk) begin
    if (!rst && result_valid) begin
      if (expect_q.size() == 0) begin
        result_errors++;
        $display("Fail %0t: result_valid with no command outstanding", $time);
      end else begin
        check_result(result, expect_q.pop_front());
      end
    end
  end

  task automatic issue_command(input mems_hub_pkg::hub_cmd_t c, input logic accept);
    @(posedge clk);
    #1;
    cmd_valid = 1'b1;
    cmd       = c;
    if (accept) begin
      expect_q.push_back(predict_result(c));
    end
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    cmd       = '0;
  endtask

  task automatic wait_result();
    int cycles;
    cycles = 0;
    while (expect_q.size() != 0 && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (expect_q.size() != 0) begin
      timeout_errors++;
      $display("timeout: no result_valid within %0d cycles", WAIT_LIMIT);
      expect_q.delete();
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (busy && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (busy) begin
      timeout_errors++;
      $display("timeout: hub still busy after %0d cycles", WAIT_LIMIT);
    end
  endtask

  task automatic run_command(input mems_hub_pkg::hub_cmd_t c);
    wait_idle();
    issue_command(c, c.mask != NO_CH);
    wait_result();
  endtask

  task automatic check_model(input logic [6:0] addr);
    peek_addr = addr;
    #1;
    for (int ch = 0; ch < `MEMS_NUM_CH; ch++) begin
      check_reg(peek_data[ch], shadow[ch][addr], "model register");
    end
  endtask

  initial begin
    mems_hub_pkg::hub_cmd_t  c;
    logic [`MEMS_NUM_CH-1:0] m;
    logic [31:0]             rnd;
    seed           = 32'h439e_adb8;
    rst            = 1'b1;
    cmd_valid      = 1'b0;
    cmd            = '0;
    peek_addr      = '0;
    result_errors  = 0;
    check_errors   = 0;
    timeout_errors = 0;
    for (int ch = 0; ch < `MEMS_NUM_CH; ch++) begin
      for (int a = 0; a < 128; a++) begin
        shadow[ch][a] = '0;
      end
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    check_bit(busy, 1'b0, "busy after reset");
    check_bit(result_valid, 1'b0, "result_valid after reset");
    for (int ch = 0; ch < `MEMS_NUM_CH; ch++) begin
      check_bit(cs_n[ch], 1'b1, "cs_n after reset");
    end
    run_command(make_cmd(mems_hub_pkg::op_read, 7'h15, 16'h0000, ALL_CH));

    // full mask write then read back
    run_command(make_cmd(mems_hub_pkg::op_write, 7'h22, 16'hbeef, ALL_CH));
    run_command(make_cmd(mems_hub_pkg::op_read, 7'h22, 16'h0000, ALL_CH));
    check_model(7'h22);

    // one channel at a time, own value each
    for (int ch = 0; ch < `MEMS_NUM_CH; ch++) begin
      m     = NO_CH;
      m[ch] = 1'b1;
      run_command(make_cmd(mems_hub_pkg::op_write, 7'h30, 16'(32'h1111 * (ch + 1)), m));
    end
    run_command(make_cmd(mems_hub_pkg::op_read, 7'h30, 16'h0000, ALL_CH));
    check_model(7'h30);

    // second command lands while the first is in flight
    wait_idle();
    issue_command(make_cmd(mems_hub_pkg::op_write, 7'h31, 16'h5a5a, ALL_CH), 1'b1);
    check_bit(busy, 1'b1, "busy during transfer");
    issue_command(make_cmd(mems_hub_pkg::op_write, 7'h31, 16'hdead, ALL_CH), 1'b0);
    wait_result();
    run_command(make_cmd(mems_hub_pkg::op_read, 7'h31, 16'h0000, ALL_CH));
    check_model(7'h31);

    for (int i = 0; i < 40; i++) begin
      rnd     = $random(seed);
      c.op    = mems_hub_pkg::hub_op_e'(rnd[0]);
      c.addr  = {3'b000, rnd[4:1]}; // small range so reads hit earlier writes
      c.mask  = rnd[8 +: `MEMS_NUM_CH];
      if (c.mask == NO_CH) begin
        c.mask[0] = 1'b1;
      end
      rnd     = $random(seed);
      c.wdata = rnd[`MEMS_DATA_W-1:0];
      run_command(c);
    end

    // zero mask is dropped
    wait_idle();
    issue_command(make_cmd(mems_hub_pkg::op_read, 7'h01, 16'h0000, NO_CH), 1'b0);
    repeat (20) begin
      @(posedge clk);
      #1;
      check_bit(busy, 1'b0, "busy after zero mask command");
    end

    $display("errors: result %0d, check %0d, timeout %0d",
             result_errors, check_errors, timeout_errors);
    if (result_errors + check_errors + timeout_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/spi_sensor_model.sv
`timescale 1ns/100ps
`default_nettype none

`include "mems_hub_macros.svh"

module spi_sensor_model (
  input  logic                    cs_n,
  input  logic                    sck,
  input  logic                    mosi,
  output logic                    miso,
  input  logic [6:0]              peek_addr,
  output logic [`MEMS_DATA_W-1:0] peek_data
);

  logic [`MEMS_DATA_W-1:0]  regs [128];
  logic [`MEMS_FRAME_W-1:0] rx_q;     // mosi bits of the current frame
  logic [7:0]               hdr_q;    // rd bit and address
  logic [4:0]               fall_cnt; // sck falling edges in this frame

  initial begin
    miso = 1'b0;
    for (int a = 0; a < 128; a++) begin
      regs[a] = '0; // unwritten registers read as zero
    end
  end

  assign peek_data = regs[peek_addr];

  // falling sck samples mosi, rising cs_n closes the frame
  always @(negedge sck or posedge cs_n) begin
    if (cs_n) begin
      if (fall_cnt == 5'(`MEMS_FRAME_W) && !rx_q[`MEMS_FRAME_W-1]) begin
        regs[rx_q[`MEMS_FRAME_W-2:`MEMS_DATA_W]] <= rx_q[`MEMS_DATA_W-1:0];
      end
      fall_cnt <= '0;
    end else begin
      rx_q     <= {rx_q[`MEMS_FRAME_W-2:0], mosi};
      fall_cnt <= fall_cnt + 5'd1;
      if (fall_cnt == 5'd7) begin
        hdr_q <= {rx_q[6:0], mosi}; // header complete with this bit
      end
    end
  end

  // rising sck puts the next bit on miso
  always @(posedge sck) begin
    logic [`MEMS_DATA_W-1:0] word;
    word = regs[hdr_q[6:0]] << (fall_cnt - 5'd8);
    if (fall_cnt >= 5'd8 && hdr_q[7]) begin
      miso <= word[`MEMS_DATA_W-1]; // register value, msb first
    end else begin
      miso <= 1'b0; // header phase and writes
    end
  end

endmodule

`default_nettype wire

//--- rtl/mems_sensor_hub.sv
`timescale 1ns/100ps
`default_nettype none

`include "mems_hub_macros.svh"

module mems_sensor_hub (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      cmd_valid,
  input  mems_hub_pkg::hub_cmd_t    cmd,
  input  logic [`MEMS_NUM_CH-1:0]   miso,
  output logic [`MEMS_NUM_CH-1:0]   mosi,
  output logic [`MEMS_NUM_CH-1:0]   sck,
  output logic [`MEMS_NUM_CH-1:0]   cs_n,
  output logic                      busy,
  output logic                      result_valid,
  output mems_hub_pkg::hub_result_t result
);

  logic [`MEMS_NUM_CH-1:0]                     start;
  mems_hub_pkg::spi_frame_t                    frame;     // shared by all channels
  logic                                        arm;
  logic [`MEMS_NUM_CH-1:0]                     arm_mask;
  mems_hub_pkg::hub_op_e                       arm_op;
  logic [`MEMS_NUM_CH-1:0]                     new_data;
  mems_hub_pkg::spi_frame_t [`MEMS_NUM_CH-1:0] data_out;

  poll_sequencer u_poll_sequencer (
    .clk          (clk),
    .rst          (rst),
    .cmd_valid    (cmd_valid),
    .cmd          (cmd),
    .collect_busy (busy),
    .start        (start),
    .frame        (frame),
    .arm          (arm),
    .arm_mask     (arm_mask),
    .arm_op       (arm_op)
  );

  for (genvar ch = 0; ch < `MEMS_NUM_CH; ch++) begin : g_ch
    mems_spi_master #(
      .CLK_DIV (`MEMS_SCK_DIV)
    ) u_mems_spi_master (
      .clk      (clk),
      .rst      (rst),
      .start    (start[ch]),
      .data_in  (frame),
      .miso     (miso[ch]),
      .mosi     (mosi[ch]),
      .sck      (sck[ch]),
      .cs_n     (cs_n[ch]),
      .busy     (),          // collector busy already covers every channel
      .new_data (new_data[ch]),
      .data_out (data_out[ch])
    );
  end

  sample_collector u_sample_collector (
    .clk          (clk),
    .rst          (rst),
    .arm          (arm),
    .arm_mask     (arm_mask),
    .arm_op       (arm_op),
    .new_data     (new_data),
    .data_out     (data_out),
    .busy         (busy),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

`default_nettype wire

//--- rtl/sample_collector.sv
`timescale 1ns/100ps
`default_nettype none

`include "mems_hub_macros.svh"

module sample_collector (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic                                        arm,
  input  logic [`MEMS_NUM_CH-1:0]                     arm_mask,
  input  mems_hub_pkg::hub_op_e                       arm_op,
  input  logic [`MEMS_NUM_CH-1:0]                     new_data,
  input  mems_hub_pkg::spi_frame_t [`MEMS_NUM_CH-1:0] data_out,
  output logic                                        busy,
  output logic                                        result_valid,
  output mems_hub_pkg::hub_result_t                   result
);

  logic                                      active_q;
  logic [`MEMS_NUM_CH-1:0]                   pending_q;    // channels still shifting
  logic [`MEMS_NUM_CH-1:0]                   pending_next;
  mems_hub_pkg::hub_op_e                     op_q;
  logic [`MEMS_NUM_CH-1:0]                   mask_q;
  logic [`MEMS_NUM_CH-1:0][`MEMS_DATA_W-1:0] rdata_q;

  assign pending_next = pending_q & ~new_data;

  // arm covers the cycle before active_q rises
  assign busy = active_q | arm;

  always_ff @(posedge clk) begin
    if (rst) begin
      active_q     <= 1'b0;
      pending_q    <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= 1'b0;
      if (arm) begin
        active_q  <= 1'b1;
        pending_q <= arm_mask;
      end else if (result_valid) begin
        active_q <= 1'b0; // busy ends with the result cycle
      end else if (active_q) begin
        pending_q <= pending_next;
        if (pending_next == '0) begin
          result_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (arm) begin
      op_q    <= arm_op;
      mask_q  <= arm_mask;
      rdata_q <= '0; // unmasked channels report zero
    end else begin
      for (int ch = 0; ch < `MEMS_NUM_CH; ch++) begin
        if (new_data[ch]) begin
          rdata_q[ch] <= data_out[ch].data;
        end
      end
    end
  end

  assign result = '{op: op_q, mask: mask_q, rdata: rdata_q};

  // a master finishing outside the current mask means a stray start
  a_done_only_when_pending: assert property (
    @(posedge clk) disable iff (rst)
    (new_data & ~pending_q) == '0
  ) else $error("new_data on channel not pending");

endmodule

`default_nettype wire

//--- rtl/poll_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "mems_hub_macros.svh"

module poll_sequencer (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          cmd_valid,
  input  mems_hub_pkg::hub_cmd_t        cmd,
  input  logic                          collect_busy,
  output logic [`MEMS_NUM_CH-1:0]       start,
  output mems_hub_pkg::spi_frame_t      frame,
  output logic                          arm,
  output logic [`MEMS_NUM_CH-1:0]       arm_mask,
  output mems_hub_pkg::hub_op_e         arm_op
);

  logic accept;
  logic is_read;

  // no queueing, anything arriving while busy is lost
  assign accept  = cmd_valid && !collect_busy && (cmd.mask != '0);
  assign is_read = (cmd.op == mems_hub_pkg::op_read);

  always_ff @(posedge clk) begin
    if (rst) begin
      start <= '0;
      arm   <= 1'b0;
    end else begin
      start <= accept ? cmd.mask : '0; // one cycle strobe per channel
      arm   <= accept;
    end
  end

  // frame and collector info, stable until the next accept
  always_ff @(posedge clk) begin
    if (accept) begin
      frame.rd   <= is_read;
      frame.addr <= cmd.addr;
      frame.data <= is_read ? '0 : cmd.wdata; // slave drives data on reads
      arm_mask   <= cmd.mask;
      arm_op     <= cmd.op;
    end
  end

  // collector busy already blocks the cycle right after arm
  a_no_start_after_arm: assert property (
    @(posedge clk) disable iff (rst)
    arm |=> (start == '0)
  ) else $error("start right after arm");

endmodule

`default_nettype wire

//--- rtl/mems_spi_master.sv
`timescale 1ns/100ps
`default_nettype none

`include "mems_hub_macros.svh"

module mems_spi_master #(
  parameter int CLK_DIV = `MEMS_SCK_DIV
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,
  input  mems_hub_pkg::spi_frame_t data_in,
  input  logic                     miso,
  output logic                     mosi,
  output logic                     sck,
  output logic                     cs_n,
  output logic                     busy,
  output logic                     new_data,
  output mems_hub_pkg::spi_frame_t data_out
);

  localparam int CTR_W = $clog2(CLK_DIV);
  localparam int BIT_W = $clog2(`MEMS_FRAME_W);
  localparam logic [CTR_W-1:0] CTR_LAST = CTR_W'(CLK_DIV - 1);
  localparam logic [CTR_W-1:0] CTR_HALF = CTR_W'(CLK_DIV / 2 - 1);
  localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`MEMS_FRAME_W - 1);

  mems_hub_pkg::spi_state_e state_q;
  mems_hub_pkg::spi_state_e state_d;
  logic [CTR_W-1:0]         cnt_q;   // position inside one sck period
  logic [CTR_W-1:0]         cnt_d;
  logic [BIT_W-1:0]         bit_q;   // bits already shifted
  logic [BIT_W-1:0]         bit_d;
  mems_hub_pkg::spi_frame_t shift_q; // tx bits out the top, rx bits in the bottom
  mems_hub_pkg::spi_frame_t shift_d;
  logic                     mosi_d;
  logic                     sck_d;
  logic                     cs_n_d;
  logic                     new_data_d;
  mems_hub_pkg::spi_frame_t data_out_d;

  assign busy = (state_q != mems_hub_pkg::spi_idle);

  always_comb begin
    state_d    = state_q;
    cnt_d      = cnt_q;
    bit_d      = bit_q;
    shift_d    = shift_q;
    mosi_d     = mosi;
    cs_n_d     = cs_n;
    new_data_d = 1'b0;
    data_out_d = data_out;

    case (state_q)
      mems_hub_pkg::spi_idle: begin
        cnt_d = '0;
        bit_d = '0;
        if (start) begin
          shift_d = data_in; // frame captured here, source may change later
          cs_n_d  = 1'b0;
          state_d = mems_hub_pkg::spi_lead;
        end
      end

      mems_hub_pkg::spi_lead: begin
        cnt_d = cnt_q + 1'b1;
        if (cnt_q == CTR_HALF) begin
          cnt_d   = '0;
          mosi_d  = shift_q[`MEMS_FRAME_W-1]; // first bit with the first rising edge
          state_d = mems_hub_pkg::spi_transfer;
        end
      end

      mems_hub_pkg::spi_transfer: begin
        cnt_d = cnt_q + 1'b1; // wraps at CLK_DIV
        if (cnt_q == CTR_HALF) begin
          // sample miso right before sck falls
          shift_d = mems_hub_pkg::spi_frame_t'({shift_q[`MEMS_FRAME_W-2:0], miso});
        end
        if (cnt_q == CTR_LAST) begin
          bit_d = bit_q + 1'b1;
          if (bit_q == BIT_LAST) begin
            data_out_d = shift_q;
            cnt_d      = '0;
            state_d    = mems_hub_pkg::spi_cs_setup;
          end else begin
            mosi_d = shift_q[`MEMS_FRAME_W-1]; // next bit on the coming rise
          end
        end
      end

      mems_hub_pkg::spi_cs_setup: begin
        cnt_d = cnt_q + 1'b1;
        if (cnt_q == CTR_HALF) begin
          cs_n_d  = 1'b1;
          cnt_d   = '0;
          state_d = mems_hub_pkg::spi_cs_hold;
        end
      end

      mems_hub_pkg::spi_cs_hold: begin
        cnt_d = cnt_q + 1'b1;
        if (cnt_q == CTR_LAST) begin
          cnt_d      = '0;
          new_data_d = 1'b1;
          state_d    = mems_hub_pkg::spi_idle;
        end
      end

      default: begin
        state_d = mems_hub_pkg::spi_idle;
      end
    endcase

    // high for the first half of each period, registered so the pin is clean
    sck_d = (state_d == mems_hub_pkg::spi_transfer) && !cnt_d[CTR_W-1];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= mems_hub_pkg::spi_idle;
      cnt_q    <= '0;
      bit_q    <= '0;
      mosi     <= 1'b0;
      sck      <= 1'b0;
      cs_n     <= 1'b1;
      new_data <= 1'b0;
    end else begin
      state_q  <= state_d;
      cnt_q    <= cnt_d;
      bit_q    <= bit_d;
      mosi     <= mosi_d;
      sck      <= sck_d;
      cs_n     <= cs_n_d;
      new_data <= new_data_d;
    end
  end

  always_ff @(posedge clk) begin
    shift_q  <= shift_d;
    data_out <= data_out_d;
  end

  // sensor must stay selected while any sck edge is produced
  a_cs_low_in_transfer: assert property (
    @(posedge clk) disable iff (rst)
    (state_q == mems_hub_pkg::spi_transfer) |-> !cs_n
  ) else $error("cs_n high during transfer");

  // the sequencer only starts idle channels
  a_no_start_when_busy: assert property (
    @(posedge clk) disable iff (rst)
    busy |-> !start
  ) else $error("start while busy");

endmodule

`default_nettype wire

//--- rtl/mems_hub_pkg.sv
`default_nettype none

`include "mems_hub_macros.svh"

package mems_hub_pkg;

  // register access type
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } hub_op_e;

  // spi master sequence
  typedef enum logic [2:0] {
    spi_idle     = 3'd0,
    spi_lead     = 3'd1, // cs low, before first sck edge
    spi_transfer = 3'd2,
    spi_cs_setup = 3'd3, // after last edge, before cs rises
    spi_cs_hold  = 3'd4  // cs high gap before done
  } spi_state_e;

  typedef struct packed {
    hub_op_e                         op;
    logic [6:0]                      addr;
    logic [`MEMS_DATA_W-1:0]         wdata;
    logic [`MEMS_NUM_CH-1:0]         mask; // one bit per channel
  } hub_cmd_t;

  // word on the wire, msb first
  typedef struct packed {
    logic                                    rd;
    logic [`MEMS_FRAME_W-`MEMS_DATA_W-2:0]   addr;
    logic [`MEMS_DATA_W-1:0]                 data;
  } spi_frame_t;

  // channel 0 sits in the lowest rdata slot
  typedef struct packed {
    hub_op_e                                 op;
    logic [`MEMS_NUM_CH-1:0]                 mask;
    logic [`MEMS_NUM_CH-1:0][`MEMS_DATA_W-1:0] rdata;
  } hub_result_t;

endpackage

`default_nettype wire

//--- rtl/mems_hub_macros.svh
`ifndef MEMS_HUB_MACROS_SVH
`define MEMS_HUB_MACROS_SVH

// sensor channels, each with its own spi bus
`define MEMS_NUM_CH 4

// system clocks per sck period, must be a power of two
`define MEMS_SCK_DIV 4

// bits per spi frame
`define MEMS_FRAME_W 24

// register value width
`define MEMS_DATA_W 16

`endif
